// File: design/rst_alpha_pkg.sv
`default_nettype none

package rst_alpha_pkg;

  typedef logic [7:0] char_t;
  typedef logic [5:0] sym_idx_t;
  typedef logic [2:0] grid_idx_t;

  // ascii bounds of the accepted ranges
  localparam char_t CHAR_UPPER_A = 8'h41;
  localparam char_t CHAR_UPPER_Z = 8'h5A;
  localparam char_t CHAR_LOWER_A = 8'h61;
  localparam char_t CHAR_LOWER_Z = 8'h7A;
  localparam char_t CHAR_DIGIT_0 = 8'h30;
  localparam char_t CHAR_DIGIT_9 = 8'h39;

  // digits follow the letters in the symbol space
  localparam int NUM_LETTERS = 26;
  localparam int GRID_DIM = 6;

  function automatic logic is_upper(char_t c);
    return (c >= CHAR_UPPER_A) && (c <= CHAR_UPPER_Z);
  endfunction

  function automatic logic is_lower(char_t c);
    return (c >= CHAR_LOWER_A) && (c <= CHAR_LOWER_Z);
  endfunction

  function automatic logic is_digit(char_t c);
    return (c >= CHAR_DIGIT_0) && (c <= CHAR_DIGIT_9);
  endfunction

  function automatic logic is_alnum(char_t c);
    return is_upper(c) || is_lower(c) || is_digit(c);
  endfunction

  // case-insensitive, zero for anything else
  function automatic sym_idx_t sym_index(char_t c);
    sym_idx_t idx;
    idx = '0;
    if (is_upper(c)) begin
      idx = sym_idx_t'(c - CHAR_UPPER_A);
    end else if (is_lower(c)) begin
      idx = sym_idx_t'(c - CHAR_LOWER_A);
    end else if (is_digit(c)) begin
      idx = sym_idx_t'(c - CHAR_DIGIT_0) + sym_idx_t'(NUM_LETTERS);
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

// File: design/rst_cipher_pkg.sv
`default_nettype none

package rst_cipher_pkg;

  localparam int KEY_LEN = 12;

  // position 0 sits in the lowest byte
  typedef rst_alpha_pkg::char_t [KEY_LEN-1:0] key_t;

  typedef struct packed {
    rst_alpha_pkg::char_t [rst_alpha_pkg::GRID_DIM-1:0] rows;
    rst_alpha_pkg::char_t [rst_alpha_pkg::GRID_DIM-1:0] cols;
  } table_t;

  typedef struct packed {
    logic                     valid;
    rst_alpha_pkg::grid_idx_t row;
    rst_alpha_pkg::grid_idx_t col;
  } sym_t;

  typedef struct packed {
    rst_alpha_pkg::char_t row_char;
    rst_alpha_pkg::char_t col_char;
  } ctxt_t;

  // key position feeding each row and column slot
  localparam int ROW_LOAD_ORDER [rst_alpha_pkg::GRID_DIM] = '{11, 1, 9, 3, 7, 5};
  localparam int COL_LOAD_ORDER [rst_alpha_pkg::GRID_DIM] = '{10, 0, 8, 2, 6, 4};

  // odd key positions go to rows, even ones to columns
  function automatic table_t load_table(key_t key);
    table_t t;
    for (int i = 0; i < rst_alpha_pkg::GRID_DIM; i++) begin
      t.rows[i] = key[ROW_LOAD_ORDER[i]];
      t.cols[i] = key[COL_LOAD_ORDER[i]];
    end
    return t;
  endfunction

endpackage

`default_nettype wire

// File: design/rst_key_check.sv
`timescale 1ns/100ps
`default_nettype none

module rst_key_check (
  input  wire rst_cipher_pkg::key_t key,
  output logic                      key_ok
);

  logic [rst_cipher_pkg::KEY_LEN-1:0] char_ok;
  logic [rst_cipher_pkg::KEY_LEN-1:0] char_dup;
  logic                               all_ok;
  logic                               any_dup;

  // class check per key position
  always_comb begin
    for (int i = 0; i < rst_cipher_pkg::KEY_LEN; i++) begin
      char_ok[i] = rst_alpha_pkg::is_alnum(key[i]);
    end
  end

  // flag a position when some later position repeats it
  always_comb begin
    char_dup = '0;
    for (int i = 0; i < rst_cipher_pkg::KEY_LEN - 1; i++) begin
      for (int j = i + 1; j < rst_cipher_pkg::KEY_LEN; j++) begin
        if (key[i] == key[j]) begin
          char_dup[i] = 1'b1;
        end
      end
    end
  end

  assign all_ok  = &char_ok;
  assign any_dup = |char_dup;

  assign key_ok = all_ok && !any_dup;

endmodule

`default_nettype wire

// File: design/rst_symbol_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rst_symbol_decode (
  input  wire                       ptxt_valid,
  input  wire rst_alpha_pkg::char_t ptxt_char,
  output rst_cipher_pkg::sym_t      sym,
  output logic                      bad_char
);

  rst_alpha_pkg::sym_idx_t sym_idx;
  logic                    alnum;

  assign alnum   = rst_alpha_pkg::is_alnum(ptxt_char);
  assign sym_idx = rst_alpha_pkg::sym_index(ptxt_char);

  // split the index into grid coordinates
  always_comb begin
    sym.valid = ptxt_valid && alnum;
    sym.row   = rst_alpha_pkg::grid_idx_t'(sym_idx / rst_alpha_pkg::GRID_DIM);
    sym.col   = rst_alpha_pkg::grid_idx_t'(sym_idx % rst_alpha_pkg::GRID_DIM);
  end

  // only a strobe can raise the error
  assign bad_char = ptxt_valid && !alnum;

endmodule

`default_nettype wire

// File: design/rst_rot_table.sv
`timescale 1ns/100ps
`default_nettype none

module rst_rot_table (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire rst_cipher_pkg::key_t key,
  input  wire                       key_ok,
  input  wire rst_cipher_pkg::sym_t sym,
  output rst_cipher_pkg::table_t    tbl,
  output logic                      step,
  output rst_cipher_pkg::sym_t      sel
);

  localparam int LAST = rst_alpha_pkg::GRID_DIM - 1;

  rst_cipher_pkg::table_t tbl_rot;
  logic                   loaded;
  logic                   load;

  // only the first good key after reset takes effect
  assign load = key_ok && !loaded;

  // symbols before load neither rotate nor produce output
  assign step = sym.valid && loaded;
  assign sel  = sym;

  // next table state after one rotation
  always_comb begin
    tbl_rot.rows = {tbl.rows[LAST-1:0], tbl.rows[LAST]};
    tbl_rot.cols = {tbl.cols[LAST-1:0], tbl.cols[LAST]};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loaded <= 1'b0;
    end else if (load) begin
      loaded <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tbl <= '0;
    end else if (load) begin
      tbl <= rst_cipher_pkg::load_table(key);
    end else if (step) begin
      tbl <= tbl_rot;
    end
  end

endmodule

`default_nettype wire

// File: design/rst_subst_result.sv
`timescale 1ns/100ps
`default_nettype none

module rst_subst_result (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire rst_cipher_pkg::table_t tbl,
  input  wire                         step,
  input  wire rst_cipher_pkg::sym_t   sel,
  input  wire                         bad_char,
  output rst_cipher_pkg::ctxt_t       ctxt,
  output logic                        ctxt_valid,
  output logic                        err_ptxt_char
);

  rst_alpha_pkg::char_t row_char;
  rst_alpha_pkg::char_t col_char;

  // lookup uses the table before this cycle's rotation
  assign row_char = tbl.rows[sel.row];
  assign col_char = tbl.cols[sel.col];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt_valid    <= 1'b0;
      err_ptxt_char <= 1'b0;
    end else begin
      ctxt_valid    <= step;
      err_ptxt_char <= bad_char;
    end
  end

  // held at zero between results
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctxt <= '0;
    end else if (step) begin
      ctxt.row_char <= row_char;
      ctxt.col_char <= col_char;
    end else begin
      ctxt <= '0;
    end
  end

endmodule

`default_nettype wire

// File: design/rst_cipher.sv
`timescale 1ns/100ps
`default_nettype none

module rst_cipher (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       ptxt_valid,
  input  wire rst_alpha_pkg::char_t ptxt_char,
  input  wire rst_cipher_pkg::key_t key,
  output rst_cipher_pkg::ctxt_t     ctxt,
  output logic                      ctxt_valid,
  output logic                      err_ptxt_char,
  output logic                      err_key
);

  logic                   key_ok;
  logic                   bad_char;
  logic                   step;
  rst_cipher_pkg::sym_t   sym;
  rst_cipher_pkg::sym_t   sel;
  rst_cipher_pkg::table_t tbl;

  // decode
  rst_key_check i_key_check (
    .key    (key),
    .key_ok (key_ok)
  );

  rst_symbol_decode i_symbol_decode (
    .ptxt_valid (ptxt_valid),
    .ptxt_char  (ptxt_char),
    .sym        (sym),
    .bad_char   (bad_char)
  );

  // execute
  rst_rot_table i_rot_table (
    .clk    (clk),
    .rst_n  (rst_n),
    .key    (key),
    .key_ok (key_ok),
    .sym    (sym),
    .tbl    (tbl),
    .step   (step),
    .sel    (sel)
  );

  // result
  rst_subst_result i_subst_result (
    .clk           (clk),
    .rst_n         (rst_n),
    .tbl           (tbl),
    .step          (step),
    .sel           (sel),
    .bad_char      (bad_char),
    .ctxt          (ctxt),
    .ctxt_valid    (ctxt_valid),
    .err_ptxt_char (err_ptxt_char)
  );

  // high while the presented key is unusable
  assign err_key = !key_ok;

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  input  wire  rst_req,
  output logic clk,
  output wire  rst_n
);

  logic por_n;

  // power-on reset, or a reset requested by the testbench
  assign rst_n = por_n && !rst_req;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  initial begin
    por_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    por_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/rst_cipher_chk.sv
`timescale 1ns/100ps
`default_nettype none

module rst_cipher_chk (
  input wire                       clk,
  input wire                       rst_n,
  input wire                       ptxt_valid,
  input wire                       ctxt_valid,
  input wire                       err_ptxt_char,
  input wire                       err_key,
  input wire rst_cipher_pkg::key_t key
);

  int fail_count = 0;

  // letters and digits only, no character used twice
  function automatic logic key_usable(rst_cipher_pkg::key_t k);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < rst_cipher_pkg::KEY_LEN; i++) begin
      if (!((k[i] >= 8'h41 && k[i] <= 8'h5a) || (k[i] >= 8'h61 && k[i] <= 8'h7a) ||
            (k[i] >= 8'h30 && k[i] <= 8'h39))) begin
        ok = 1'b0;
      end
      for (int j = 0; j < i; j++) begin
        if (k[i] == k[j]) begin
          ok = 1'b0;
        end
      end
    end
    return ok;
  endfunction

  // a strobe yields a result or an error, never both
  a_one_outcome: assert property (
    @(posedge clk) disable iff (!rst_n) !(ctxt_valid && err_ptxt_char)
  ) else begin
    fail_count++;
    $error("ctxt_valid and err_ptxt_char high in the same cycle");
  end

  a_result_after_strobe: assert property (
    @(posedge clk) disable iff (!rst_n) ctxt_valid |-> $past(ptxt_valid)
  ) else begin
    fail_count++;
    $error("ctxt_valid without a strobe in the cycle before");
  end

  a_error_after_strobe: assert property (
    @(posedge clk) disable iff (!rst_n) err_ptxt_char |-> $past(ptxt_valid)
  ) else begin
    fail_count++;
    $error("err_ptxt_char without a strobe in the cycle before");
  end

  // key flag follows the key itself
  a_key_flag: assert property (
    @(posedge clk) err_key == !key_usable(key)
  ) else begin
    fail_count++;
    $error("err_key does not match the validity of the presented key");
  end

endmodule

bind rst_cipher rst_cipher_chk i_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .ptxt_valid    (ptxt_valid),
  .ctxt_valid    (ctxt_valid),
  .err_ptxt_char (err_ptxt_char),
  .err_key       (err_key),
  .key           (key)
);

`default_nettype wire

// File: tb/tb_rst_cipher.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rst_cipher;

  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_CASES    = 64;
  localparam int PAD_COUNT    = 24;
  localparam int ROW_ORDER [6] = '{11, 1, 9, 3, 7, 5};
  localparam int COL_ORDER [6] = '{10, 0, 8, 2, 6, 4};

  logic                  clk;
  wire                   rst_n;
  logic                  rst_req;
  logic                  ptxt_valid;
  rst_alpha_pkg::char_t  ptxt_char;
  rst_cipher_pkg::key_t  key;
  rst_cipher_pkg::ctxt_t ctxt;
  logic                  ctxt_valid;
  logic                  err_ptxt_char;
  logic                  err_key;

  logic [7:0]  case_op   [MAX_CASES];
  logic [95:0] case_data [MAX_CASES];
  logic        case_v    [MAX_CASES];
  logic [15:0] case_ctxt [MAX_CASES];
  logic        case_e    [MAX_CASES];
  logic        case_k    [MAX_CASES];
  int          n_cases = 0;
  bit          cases_ready = 1'b0;
  int          errors = 0;
  integer      seed = 32'hb040_6fe1;

  // reference model
  logic [95:0] m_key;
  logic        m_loaded;
  logic [7:0]  m_rows [6];
  logic [7:0]  m_cols [6];

  // expected outputs of the previous cycle
  logic        pend = 1'b0;
  int          pend_tag;
  logic        pend_v;
  logic [15:0] pend_c;
  logic        pend_e;

  tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clk_gen (
    .rst_req (rst_req),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  rst_cipher i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .ptxt_valid    (ptxt_valid),
    .ptxt_char     (ptxt_char),
    .key           (key),
    .ctxt          (ctxt),
    .ctxt_valid    (ctxt_valid),
    .err_ptxt_char (err_ptxt_char),
    .err_key       (err_key)
  );

  function automatic logic alnum(input logic [7:0] c);
    return (c >= 8'h41 && c <= 8'h5a) || (c >= 8'h61 && c <= 8'h7a) ||
           (c >= 8'h30 && c <= 8'h39);
  endfunction

  // letters 0..25 in either case, digits after them
  function automatic int symbol_of(input logic [7:0] c);
    if (c >= 8'h61) return c - 8'h61;
    if (c >= 8'h41) return c - 8'h41;
    return c - 8'h30 + 26;
  endfunction

  function automatic logic key_good(input logic [95:0] k);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < 12; i++) begin
      if (!alnum(k[8*i +: 8])) ok = 1'b0;
      for (int j = 0; j < i; j++) begin
        if (k[8*i +: 8] == k[8*j +: 8]) ok = 1'b0;
      end
    end
    return ok;
  endfunction

  task automatic model_cycle(input logic [7:0] op, input logic [95:0] data,
                             output logic exp_v, output logic [15:0] exp_c,
                             output logic exp_e);
    int         sym;
    logic [7:0] prev_rows [6];
    logic [7:0] prev_cols [6];
    exp_v = 1'b0;
    exp_c = '0;
    exp_e = (op == "P") && !alnum(data[7:0]);
    if (op == "R") begin
      m_loaded = 1'b0;
      for (int i = 0; i < 6; i++) begin
        m_rows[i] = '0;
        m_cols[i] = '0;
      end
    end else begin
      if (op == "K") m_key = data;
      if (op == "P" && alnum(data[7:0]) && m_loaded) begin
        sym = symbol_of(data[7:0]);
        exp_v = 1'b1;
        exp_c = {m_rows[sym / 6], m_cols[sym % 6]};
        prev_rows = m_rows;
        prev_cols = m_cols;
        // row 0 takes the old row 5
        for (int i = 0; i < 6; i++) begin
          m_rows[i] = prev_rows[(i + 5) % 6];
          m_cols[i] = prev_cols[(i + 5) % 6];
        end
      end else if (!m_loaded && key_good(m_key)) begin
        m_loaded = 1'b1;
        for (int i = 0; i < 6; i++) begin
          m_rows[i] = m_key[8*ROW_ORDER[i] +: 8];
          m_cols[i] = m_key[8*COL_ORDER[i] +: 8];
        end
      end
    end
  endtask

  task automatic drive_cycle(input logic [7:0] op, input logic [95:0] data);
    @(posedge clk);
    ptxt_valid <= (op == "P");
    rst_req    <= (op == "R");
    if (op == "K") key <= data;
    if (op == "P" || op == "N") ptxt_char <= data[7:0];
  endtask

  task automatic check_cycle(input int tag, input logic exp_k, input logic exp_v,
                             input logic [15:0] exp_c, input logic exp_e);
    @(negedge clk);
    if (pend) begin
      assert (ctxt_valid === pend_v) else begin
        errors++;
        $display("[FAIL] ctxt_valid: expected %h, got %h (step %0d)", pend_v, ctxt_valid,
                 pend_tag);
      end
      assert (ctxt === pend_c) else begin
        errors++;
        $display("[FAIL] ctxt: expected %h, got %h (step %0d)", pend_c, ctxt, pend_tag);
      end
      assert (err_ptxt_char === pend_e) else begin
        errors++;
        $display("[FAIL] err_ptxt_char: expected %h, got %h (step %0d)", pend_e,
                 err_ptxt_char, pend_tag);
      end
    end
    assert (err_key === exp_k) else begin
      errors++;
      $display("[FAIL] err_key: expected %h, got %h (step %0d)", exp_k, err_key, tag);
    end
    pend     = 1'b1;
    pend_tag = tag;
    pend_v   = exp_v;
    pend_c   = exp_c;
    pend_e   = exp_e;
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [95:0] data;
    logic        v;
    logic [15:0] c;
    logic        e;
    logic        k;
    fd = $fopen("tb/rst_cipher_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file tb/rst_cipher_cases.txt");
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%c %h %h %h %h %h", op, data, v, c, e, k);
        if (n == 6 && (op == "K" || op == "P" || op == "R")) begin
          case_op[n_cases]   = op;
          case_data[n_cases] = data;
          case_v[n_cases]    = v;
          case_ctxt[n_cases] = c;
          case_e[n_cases]    = e;
          case_k[n_cases]    = k;
          n_cases++;
        end else begin
          errors++;
          $display("unreadable line in the case file: %s", line);
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    wait (cases_ready);
    #((n_cases + PAD_COUNT + 1) * 4 * PERIOD_NS + RESET_CYCLES * PERIOD_NS);
    $display("timeout: the run did not reach its end in the allowed time");
    $display("Something failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  op;
    logic [95:0] data;
    logic        exp_v;
    logic [15:0] exp_c;
    logic        exp_e;
    int          total;
    rst_req    = 1'b0;
    ptxt_valid = 1'b0;
    ptxt_char  = '0;
    key        = '0;
    m_key      = '0;
    model_cycle("R", '0, exp_v, exp_c, exp_e);
    read_cases();
    if (n_cases == 0) begin
      errors++;
      $display("no cases were read from the case file");
    end
    cases_ready = 1'b1;
    @(posedge rst_n);
    for (int i = 0; i < n_cases; i++) begin
      model_cycle(case_op[i], case_data[i], exp_v, exp_c, exp_e);
      drive_cycle(case_op[i], case_data[i]);
      check_cycle(i + 1, case_k[i], case_v[i], case_ctxt[i], case_e[i]);
    end
    // random tail, mostly strobes with a mix of good and bad characters
    for (int p = 0; p <= PAD_COUNT; p++) begin
      r = $random(seed);
      op = (r[9:8] != 2'b00 && p < PAD_COUNT) ? "P" : "N";
      data = {89'h0, r[6:0]};
      model_cycle(op, data, exp_v, exp_c, exp_e);
      drive_cycle(op, data);
      check_cycle(n_cases + p + 1, !key_good(m_key), exp_v, exp_c, exp_e);
    end
    total = errors + i_dut.i_chk.fail_count;
    $display("done: %0d check errors, %0d assertion failures over %0d cases and %0d padding",
             errors, i_dut.i_chk.fail_count, n_cases, PAD_COUNT);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/rst_cipher_cases.txt
# op data exp_ctxt_valid exp_ctxt exp_err_ptxt_char exp_err_key
# op K = key (position 11 first), P = plaintext char, R = reset; all values hex
# bad keys, repeated then punctuation
K 3250784d6239547234596565 0 0000 0 1
P 61 0 0000 0 1
K 2150784d623954723459654b 0 0000 0 1
P 30 0 0000 0 1
P 21 0 0000 1 1
# good key, then 'a' once round the ring
K 3250784d623954723459654b 0 0000 0 0
P 61 1 3250 0 0
P 61 1 5472 0 0
P 61 1 6239 0 0
P 61 1 3459 0 0
P 61 1 784d 0 0
P 61 1 654b 0 0
# loaded state again, '0' is row 4 col 2
P 30 1 624d 0 0
P 21 0 0000 1 0
P 51 1 6559 0 0
P 7a 1 7872 0 0
P 39 1 784d 0 0
P 4d 1 624d 0 0
P 35 1 324d 0 0
P 20 0 0000 1 0
P 68 1 654b 0 0
# same ring state as 'Q'
P 71 1 6559 0 0
# second key has no effect until reset
K 6c6b6a696867666564636261 0 0000 0 0
P 61 1 6239 0 0
K 6c6b6a696867666564636261 0 0000 0 0
R 0 0 0000 0 0
P 61 0 0000 0 0
P 61 1 6c6b 0 0
P 30 1 6461 0 0
P 2e 0 0000 1 0
# bad key after load, table keeps working
K 3250784d6239547234596565 0 0000 0 1
P 5a 1 6a65 0 1

// File: rst_cipher.f
design/rst_alpha_pkg.sv
design/rst_cipher_pkg.sv
design/rst_key_check.sv
design/rst_symbol_decode.sv
design/rst_rot_table.sv
design/rst_subst_result.sv
design/rst_cipher.sv
tb/tb_clk_gen.sv
tb/rst_cipher_chk.sv
tb/tb_rst_cipher.sv
